/* source/csr_mem_pkg.sv */
package csr_mem_pkg;

    // --------------------
    // Memory packet widths
    // --------------------
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int MOD_ID_W = 1;

    // Routed peers on the response stream
    localparam logic [MOD_ID_W-1:0] MOD_CONFIGURE = 1'b0;
    localparam logic [MOD_ID_W-1:0] MOD_GENERATOR = 1'b1;
    localparam int                  NUM_MODULES   = 2;

    // --------------------
    // Address and word
    // --------------------
    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] mem_data_t;

endpackage : csr_mem_pkg

/* source/csr_cfg_pkg.sv */
package csr_cfg_pkg;

    // --------------------
    // Field selector codes
    // --------------------
    localparam int CFG_FIELD_W = 2;
    localparam int CFG_VALUE_W = 16;

    localparam logic [CFG_FIELD_W-1:0] CFG_OFFSET = 2'd0;
    localparam logic [CFG_FIELD_W-1:0] CFG_STRIDE = 2'd1;
    localparam logic [CFG_FIELD_W-1:0] CFG_COUNT  = 2'd2;

    // Bits between selector and value
    localparam int CFG_PAD_W = csr_mem_pkg::DATA_W - CFG_FIELD_W - CFG_VALUE_W;

    // --------------------
    // Response word views
    // --------------------
    typedef struct packed {
        logic [CFG_FIELD_W-1:0] field;
        logic [CFG_PAD_W-1:0]   reserved;
        logic [CFG_VALUE_W-1:0] value;
    } cfg_word_t;

    // Configuration words and vertex data share one response word
    typedef union packed {
        cfg_word_t              cfg;
        csr_mem_pkg::mem_data_t vertex;
    } resp_word_u;

endpackage : csr_cfg_pkg

/* source/csr_sync_fifo.sv */
`timescale 1ns/100ps

module csr_sync_fifo #(
    parameter int DATA_WIDTH  = 32,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                  ap_clk,
    input  logic                  areset_csr_engine,
    input  logic                  wr_en_i,
    input  logic [DATA_WIDTH-1:0] din_i,
    input  logic                  rd_en_i,
    output logic [DATA_WIDTH-1:0] dout_o,
    output logic                  valid_o,
    output logic                  empty_o,
    output logic                  full_o,
    output logic                  prog_full_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      occupancy;
    logic                  do_wr;
    logic                  do_rd;

    // Writes to a full FIFO and reads of an empty one are dropped
    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    assign empty_o     = (occupancy == '0);
    assign full_o      = (occupancy == CNT_W'(FIFO_DEPTH));
    assign prog_full_o = (occupancy >= CNT_W'(PROG_THRESH));

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            valid_o   <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                occupancy <= occupancy + 1'b1;
            end else if (do_rd && !do_wr) begin
                occupancy <= occupancy - 1'b1;
            end
            valid_o <= do_rd;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din_i;
        end
        if (do_rd) begin
            dout_o <= mem[rd_ptr];
        end
    end

endmodule : csr_sync_fifo

/* source/csr_resp_router.sv */
`timescale 1ns/100ps

module csr_resp_router (
    input  logic                             ap_clk,
    input  logic                             areset_csr_engine,
    input  logic                             fifo_empty_i,
    input  logic                             fifo_valid_i,
    input  logic [csr_mem_pkg::MOD_ID_W-1:0] fifo_id_i,
    input  csr_mem_pkg::mem_data_t           fifo_word_i,
    input  logic                             fwd_stall_i,
    output logic                             fifo_rd_en_o,
    output logic                             cfg_valid_o,
    output logic                             gen_valid_o,
    output csr_mem_pkg::mem_data_t           word_o
);
    import csr_mem_pkg::*;

    logic [NUM_MODULES-1:0] steer_d;
    logic [NUM_MODULES-1:0] steer_q;

    // Hold the stream while the output side is backed up
    assign fifo_rd_en_o = !fifo_empty_i && !fwd_stall_i;

    // One-hot select of the peer that owns this word
    always_comb begin
        steer_d = '0;
        if (fifo_valid_i) begin
            steer_d[fifo_id_i] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            steer_q <= '0;
        end else begin
            steer_q <= steer_d;
        end
    end

    always_ff @(posedge ap_clk) begin
        word_o <= fifo_word_i;
    end

    assign cfg_valid_o = steer_q[MOD_CONFIGURE];
    assign gen_valid_o = steer_q[MOD_GENERATOR];

endmodule : csr_resp_router

/* source/csr_index_configure.sv */
`timescale 1ns/100ps

module csr_index_configure (
    input  logic                                ap_clk,
    input  logic                                areset_csr_engine,
    input  logic                                cfg_valid_i,
    input  csr_mem_pkg::mem_data_t              word_i,
    output logic [csr_cfg_pkg::CFG_VALUE_W-1:0] offset_o,
    output logic [csr_cfg_pkg::CFG_VALUE_W-1:0] stride_o,
    output logic [csr_cfg_pkg::CFG_VALUE_W-1:0] count_o,
    output logic                                cfg_ready_o
);
    import csr_cfg_pkg::*;

    resp_word_u resp_word;
    logic [2:0] seen_q;

    assign resp_word = word_i;

    // --------------------
    // Field tracking
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_q <= '0;
        end else if (cfg_valid_i) begin
            case (resp_word.cfg.field)
                CFG_OFFSET: seen_q[0] <= 1'b1;
                CFG_STRIDE: seen_q[1] <= 1'b1;
                CFG_COUNT:  seen_q[2] <= 1'b1;
                default:    seen_q    <= seen_q;
            endcase
        end
    end

    // Latest write of a field wins
    always_ff @(posedge ap_clk) begin
        if (cfg_valid_i) begin
            case (resp_word.cfg.field)
                CFG_OFFSET: offset_o <= resp_word.cfg.value;
                CFG_STRIDE: stride_o <= resp_word.cfg.value;
                CFG_COUNT:  count_o  <= resp_word.cfg.value;
                default:    ;
            endcase
        end
    end

    // Ready stays up once every field has arrived
    assign cfg_ready_o = &seen_q;

endmodule : csr_index_configure

/* source/csr_index_generator.sv */
`timescale 1ns/100ps

module csr_index_generator (
    input  logic                                ap_clk,
    input  logic                                areset_csr_engine,
    input  logic                                start_i,
    input  csr_mem_pkg::mem_addr_t              base_addr_i,
    input  logic                                cfg_ready_i,
    input  logic [csr_cfg_pkg::CFG_VALUE_W-1:0] offset_i,
    input  logic [csr_cfg_pkg::CFG_VALUE_W-1:0] stride_i,
    input  logic [csr_cfg_pkg::CFG_VALUE_W-1:0] count_i,
    input  logic                                req_prog_full_i,
    input  logic                                gen_valid_i,
    input  csr_mem_pkg::mem_data_t              word_i,
    output logic                                req_push_o,
    output csr_mem_pkg::mem_addr_t              req_addr_o,
    output logic                                out_push_o,
    output csr_mem_pkg::mem_data_t              out_word_o,
    output logic                                done_o
);
    import csr_mem_pkg::*;
    import csr_cfg_pkg::*;

    localparam logic [1:0] S_IDLE     = 2'd0;
    localparam logic [1:0] S_WAIT_CFG = 2'd1;
    localparam logic [1:0] S_RUN      = 2'd2;

    logic [1:0]             state_q;
    mem_addr_t              base_q;
    mem_addr_t              addr_q;
    logic [CFG_VALUE_W-1:0] req_cnt_q;
    logic [CFG_VALUE_W-1:0] data_cnt_q;
    logic [CFG_VALUE_W-1:0] req_cnt_nxt;
    logic [CFG_VALUE_W-1:0] data_cnt_nxt;
    logic                   run_done;
    resp_word_u             resp_word;

    // --------------------
    // Data forwarding
    // --------------------
    assign resp_word  = word_i;
    assign out_push_o = gen_valid_i;
    assign out_word_o = resp_word.vertex;

    // --------------------
    // Request issue
    // --------------------
    assign req_push_o = (state_q == S_RUN) && (req_cnt_q != count_i) && !req_prog_full_i;
    assign req_addr_o = addr_q;

    // Counts including this cycle's events, so done follows the last one
    assign req_cnt_nxt  = req_cnt_q + CFG_VALUE_W'(req_push_o);
    assign data_cnt_nxt = data_cnt_q + CFG_VALUE_W'(gen_valid_i);
    assign run_done     = (req_cnt_nxt == count_i) && (data_cnt_nxt == count_i);

    assign done_o = (state_q == S_IDLE);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q    <= S_IDLE;
            req_cnt_q  <= '0;
            data_cnt_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_WAIT_CFG;
                    end
                end
                S_WAIT_CFG: begin
                    if (cfg_ready_i) begin
                        state_q    <= S_RUN;
                        req_cnt_q  <= '0;
                        data_cnt_q <= '0;
                    end
                end
                S_RUN: begin
                    req_cnt_q  <= req_cnt_nxt;
                    data_cnt_q <= data_cnt_nxt;
                    if (run_done) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Base capture and running address
    always_ff @(posedge ap_clk) begin
        if (state_q == S_IDLE && start_i) begin
            base_q <= base_addr_i;
        end
        if (state_q == S_WAIT_CFG) begin
            addr_q <= base_q + mem_addr_t'(offset_i);
        end else if (req_push_o) begin
            addr_q <= addr_q + mem_addr_t'(stride_i);
        end
    end

endmodule : csr_index_generator

/* source/engine_csr_index.sv */
`timescale 1ns/100ps

module engine_csr_index #(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                             ap_clk,
    input  logic                             areset_csr_engine,
    input  logic                             start_i,
    input  csr_mem_pkg::mem_addr_t           base_addr_i,
    input  logic                             mem_resp_valid_i,
    input  logic [csr_mem_pkg::MOD_ID_W-1:0] mem_resp_id_i,
    input  csr_mem_pkg::mem_data_t           mem_resp_data_i,
    output logic                             mem_resp_prog_full_o,
    input  logic                             mem_req_rd_en_i,
    output logic                             mem_req_valid_o,
    output csr_mem_pkg::mem_addr_t           mem_req_addr_o,
    input  logic                             eng_out_rd_en_i,
    output logic                             eng_out_valid_o,
    output csr_mem_pkg::mem_data_t           eng_out_data_o,
    output logic                             done_o
);
    import csr_mem_pkg::*;
    import csr_cfg_pkg::*;

    localparam int RESP_W = MOD_ID_W + DATA_W;

    logic                   start_q;
    mem_addr_t              base_q;

    logic [RESP_W-1:0]      resp_dout;
    logic                   resp_rd_en;
    logic                   resp_valid;
    logic                   resp_empty;

    logic                   cfg_valid;
    logic                   gen_valid;
    mem_data_t              routed_word;
    logic                   out_prog_full;

    logic [CFG_VALUE_W-1:0] cfg_offset;
    logic [CFG_VALUE_W-1:0] cfg_stride;
    logic [CFG_VALUE_W-1:0] cfg_count;
    logic                   cfg_ready;

    logic                   req_push;
    mem_addr_t              req_addr;
    logic                   req_prog_full;
    logic                   out_push;
    mem_data_t              out_word;

    // --------------------
    // Descriptor register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            start_q <= 1'b0;
        end else begin
            start_q <= start_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        base_q <= base_addr_i;
    end

    // --------------------
    // Memory response path
    // --------------------
    csr_sync_fifo #(
        .DATA_WIDTH (RESP_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_resp_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en_i          (mem_resp_valid_i),
        .din_i            ({mem_resp_id_i, mem_resp_data_i}),
        .rd_en_i          (resp_rd_en),
        .dout_o           (resp_dout),
        .valid_o          (resp_valid),
        .empty_o          (resp_empty),
        .full_o           (),
        .prog_full_o      (mem_resp_prog_full_o)
    );

    csr_resp_router u_router (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .fifo_empty_i     (resp_empty),
        .fifo_valid_i     (resp_valid),
        .fifo_id_i        (resp_dout[DATA_W +: MOD_ID_W]),
        .fifo_word_i      (resp_dout[DATA_W-1:0]),
        .fwd_stall_i      (out_prog_full),
        .fifo_rd_en_o     (resp_rd_en),
        .cfg_valid_o      (cfg_valid),
        .gen_valid_o      (gen_valid),
        .word_o           (routed_word)
    );

    // --------------------
    // Peers
    // --------------------
    csr_index_configure u_configure (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .cfg_valid_i      (cfg_valid),
        .word_i           (routed_word),
        .offset_o         (cfg_offset),
        .stride_o         (cfg_stride),
        .count_o          (cfg_count),
        .cfg_ready_o      (cfg_ready)
    );

    csr_index_generator u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .start_i          (start_q),
        .base_addr_i      (base_q),
        .cfg_ready_i      (cfg_ready),
        .offset_i         (cfg_offset),
        .stride_i         (cfg_stride),
        .count_i          (cfg_count),
        .req_prog_full_i  (req_prog_full),
        .gen_valid_i      (gen_valid),
        .word_i           (routed_word),
        .req_push_o       (req_push),
        .req_addr_o       (req_addr),
        .out_push_o       (out_push),
        .out_word_o       (out_word),
        .done_o           (done_o)
    );

    // --------------------
    // Request and output streams
    // --------------------
    csr_sync_fifo #(
        .DATA_WIDTH (ADDR_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_req_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en_i          (req_push),
        .din_i            (req_addr),
        .rd_en_i          (mem_req_rd_en_i),
        .dout_o           (mem_req_addr_o),
        .valid_o          (mem_req_valid_o),
        .empty_o          (),
        .full_o           (),
        .prog_full_o      (req_prog_full)
    );

    // Prog full here throttles the router, not the generator
    csr_sync_fifo #(
        .DATA_WIDTH (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_out_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .wr_en_i          (out_push),
        .din_i            (out_word),
        .rd_en_i          (eng_out_rd_en_i),
        .dout_o           (eng_out_data_o),
        .valid_o          (eng_out_valid_o),
        .empty_o          (),
        .full_o           (),
        .prog_full_o      (out_prog_full)
    );

endmodule : engine_csr_index

/* sim/engine_csr_index_assert.sv */
`timescale 1ns/100ps

module engine_csr_index_assert #(
    parameter int FIFO_DEPTH = 16,
    parameter int CNT_W      = 5
) (
    input logic             ap_clk,
    input logic             areset_csr_engine,
    input logic             rd_en_i,
    input logic             empty_i,
    input logic             valid_i,
    input logic [CNT_W-1:0] occupancy_i
);

    // A read of an empty FIFO returns nothing
    empty_read_quiet : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (rd_en_i && empty_i) |=> !valid_i
    ) else $error("valid_o rose after a read of an empty FIFO");

    occupancy_bounded : assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        occupancy_i <= CNT_W'(FIFO_DEPTH)
    ) else $error("FIFO occupancy above its depth");

endmodule : engine_csr_index_assert

bind csr_sync_fifo engine_csr_index_assert #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .CNT_W     (CNT_W)
) fifo_checks (
    .ap_clk           (ap_clk),
    .areset_csr_engine(areset_csr_engine),
    .rd_en_i          (rd_en_i),
    .empty_i          (empty_o),
    .valid_i          (valid_o),
    .occupancy_i      (occupancy)
);

/* sim/tb_engine_csr_index.sv */
`timescale 1ns/100ps

module tb_engine_csr_index;
    import csr_mem_pkg::*;
    import csr_cfg_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam int          COUNT_RUN1   = 5;
    localparam int          COUNT_RUN2   = 20;
    localparam int          STALL_CYCLES = 60;
    // Worst case per word: request pop, response delay, output pop, plus stalls
    localparam int          WATCHDOG_CYCLES = (COUNT_RUN1 + COUNT_RUN2) * 40
                                              + 4 * STALL_CYCLES + 200;
    localparam logic [31:0] SEED = 32'h7cdb_976b;

    logic                ap_clk = 1'b0;
    logic                areset_csr_engine;
    logic                start_i;
    mem_addr_t           base_addr_i;
    logic                mem_resp_valid_i;
    logic [MOD_ID_W-1:0] mem_resp_id_i;
    mem_data_t           mem_resp_data_i;
    logic                mem_resp_prog_full_o;
    logic                mem_req_rd_en_i;
    logic                mem_req_valid_o;
    mem_addr_t           mem_req_addr_o;
    logic                eng_out_rd_en_i;
    logic                eng_out_valid_o;
    mem_data_t           eng_out_data_o;
    logic                done_o;

    mem_addr_t   exp_req[$];
    mem_data_t   exp_out[$];
    mem_addr_t   pending[$];
    mem_data_t   cfg_words[$];
    int unsigned errors = 0;
    int unsigned checks = 0;
    logic        req_hold;
    logic        out_hold;
    logic        req_full_seen;
    logic        resp_full_seen;

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    engine_csr_index #(
        .FIFO_DEPTH (16),
        .PROG_THRESH(8)
    ) dut0 (.*);

    // Memory contents as seen by the engine
    function automatic mem_data_t memory_word(input mem_addr_t addr);
        return addr * 32'd3 + 32'h11;
    endfunction

    function automatic mem_data_t cfg_word(input logic [CFG_FIELD_W-1:0] field,
                                           input logic [CFG_VALUE_W-1:0] value);
        return {field, {CFG_PAD_W{1'b0}}, value};
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic raise_problem(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic apply_reset();
        areset_csr_engine = 1'b1;
        repeat (3) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;
    endtask

    task automatic queue_run(input mem_addr_t base, input logic [15:0] offset,
                             input logic [15:0] stride, input logic [15:0] count);
        mem_addr_t addr;
        for (int k = 0; k < count; k++) begin
            addr = base + {16'h0, offset} + 32'(k) * {16'h0, stride};
            exp_req.push_back(addr);
            exp_out.push_back(memory_word(addr));
        end
    endtask

    // Descriptor strobe, then done must fall after two edges
    task automatic start_run(input mem_addr_t base);
        @(posedge ap_clk);
        #1;
        start_i     = 1'b1;
        base_addr_i = base;
        @(posedge ap_clk);
        #1;
        start_i = 1'b0;
        assert (done_o) else log_mismatch("done_o fell one cycle after start");
        @(posedge ap_clk);
        #1;
        assert (!done_o) else log_mismatch("done_o still high two cycles after start");
    endtask

    task automatic finish_run(input int unsigned limit);
        int unsigned n;
        n = 0;
        while (!done_o && n < limit) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        if (!done_o) begin
            raise_problem("Timed out waiting for done_o to rise");
        end else begin
            assert (exp_req.size() == 0 && pending.size() == 0)
                else log_mismatch("done_o rose before all requests were answered");
        end
        n = 0;
        while (exp_out.size() != 0 && n < limit) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        if (exp_out.size() != 0) begin
            raise_problem("Timed out waiting for the remaining output words");
        end
    endtask

    // --------------------
    // Memory model and output reader
    // --------------------
    initial begin : drive_outside
        mem_req_rd_en_i  = 1'b0;
        eng_out_rd_en_i  = 1'b0;
        mem_resp_valid_i = 1'b0;
        mem_resp_id_i    = '0;
        mem_resp_data_i  = '0;
        req_full_seen    = 1'b0;
        resp_full_seen   = 1'b0;
        forever begin
            @(posedge ap_clk);
            #1;
            if (mem_req_valid_o) begin
                pending.push_back(mem_req_addr_o);
            end
            if (!mem_req_rd_en_i && dut0.req_prog_full) begin
                req_full_seen = 1'b1;
            end
            if (out_hold && mem_resp_prog_full_o) begin
                resp_full_seen = 1'b1;
            end
            mem_req_rd_en_i  = !req_hold && (($urandom % 3) != 0);
            eng_out_rd_en_i  = !out_hold && (($urandom % 4) != 0);
            mem_resp_valid_i = 1'b0;
            if (!mem_resp_prog_full_o) begin
                if (cfg_words.size() != 0) begin
                    mem_resp_valid_i = 1'b1;
                    mem_resp_id_i    = MOD_CONFIGURE;
                    mem_resp_data_i  = cfg_words.pop_front();
                end else if (pending.size() != 0) begin
                    if (resp_wait_done()) begin
                        mem_resp_valid_i = 1'b1;
                        mem_resp_id_i    = MOD_GENERATOR;
                        mem_resp_data_i  = memory_word(pending.pop_front());
                    end
                end
            end
        end
    end

    // Random gap before each data response
    int unsigned resp_wait = 0;
    function automatic logic resp_wait_done();
        if (resp_wait == 0) begin
            resp_wait = $urandom % 4;
            return 1'b1;
        end
        resp_wait--;
        return 1'b0;
    endfunction

    // --------------------
    // Comparing process
    // --------------------
    initial begin : compare
        mem_addr_t exp_a;
        mem_data_t exp_d;
        forever begin
            @(posedge ap_clk);
            #1;
            if (mem_req_valid_o) begin
                checks++;
                assert (exp_req.size() != 0) else raise_problem("Request popped with none expected");
                if (exp_req.size() != 0) begin
                    exp_a = exp_req.pop_front();
                    assert (mem_req_addr_o == exp_a) else log_mismatch(
                        $sformatf("request address %h, expected %h", mem_req_addr_o, exp_a));
                end
            end
            if (eng_out_valid_o) begin
                checks++;
                assert (exp_out.size() != 0) else raise_problem("Output word with none expected");
                if (exp_out.size() != 0) begin
                    exp_d = exp_out.pop_front();
                    assert (eng_out_data_o == exp_d) else log_mismatch(
                        $sformatf("output word %h, expected %h", eng_out_data_o, exp_d));
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Watchdog expired after %0d cycles, checks: %0d, errors: %0d",
                 WATCHDOG_CYCLES, checks, errors + 1);
        $display("Test failed");
        $finish;
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin : main_sequence
        mem_addr_t   base;
        int unsigned n;
        void'($urandom(SEED));
        start_i     = 1'b0;
        base_addr_i = '0;
        req_hold    = 1'b0;
        out_hold    = 1'b0;
        apply_reset();
        assert (done_o && !mem_req_valid_o && !eng_out_valid_o && !mem_resp_prog_full_o)
            else log_mismatch("outputs not idle after reset");

        // Run 1, offset written twice and output stalled for a while
        base = $urandom & 32'hffff_fff0;
        queue_run(base, 16'd8, 16'd4, 16'd5);
        out_hold = 1'b1;
        start_run(base);
        cfg_words.push_back(cfg_word(CFG_OFFSET, 16'd2));
        cfg_words.push_back(cfg_word(CFG_OFFSET, 16'd8));
        cfg_words.push_back(cfg_word(CFG_STRIDE, 16'd4));
        cfg_words.push_back(cfg_word(CFG_COUNT, 16'd5));
        repeat (STALL_CYCLES) @(posedge ap_clk);
        #1;
        out_hold = 1'b0;
        finish_run(COUNT_RUN1 * 40 + STALL_CYCLES);

        // Run 2, request and output sides both held at first
        apply_reset();
        base = $urandom & 32'hffff_fff0;
        queue_run(base, 16'd3, 16'd1, 16'd20);
        req_hold = 1'b1;
        out_hold = 1'b1;
        start_run(base);
        cfg_words.push_back(cfg_word(CFG_OFFSET, 16'd3));
        cfg_words.push_back(cfg_word(CFG_STRIDE, 16'd1));
        cfg_words.push_back(cfg_word(CFG_COUNT, 16'd20));
        n = 0;
        while (!req_full_seen && n < STALL_CYCLES) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        assert (req_full_seen) else raise_problem("Request FIFO never reached prog_full");
        req_hold = 1'b0;
        n = 0;
        while (!resp_full_seen && n < COUNT_RUN2 * 20) begin
            @(posedge ap_clk);
            #1;
            n++;
        end
        assert (resp_full_seen) else raise_problem("Response prog_full never rose under stall");
        out_hold = 1'b0;
        finish_run(COUNT_RUN2 * 40 + STALL_CYCLES);

        repeat (10) @(posedge ap_clk);
        assert (checks == 2 * (COUNT_RUN1 + COUNT_RUN2))
            else raise_problem("Wrong number of requests and output words seen");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_engine_csr_index

/* files.f */
source/csr_mem_pkg.sv
source/csr_cfg_pkg.sv
source/csr_sync_fifo.sv
source/csr_resp_router.sv
source/csr_index_configure.sv
source/csr_index_generator.sv
source/engine_csr_index.sv
sim/engine_csr_index_assert.sv
sim/tb_engine_csr_index.sv

/* Makefile */
TOP := tb_engine_csr_index

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
